// File: sources.f
hw/chip_ctrl_pkg.sv
hw/apb_region_demux.sv
hw/clk_ctrl_regs.sv
hw/pad_cfg_regs.sv
hw/pad_mux.sv
hw/chip_ctrl_top.sv
tests/chip_ctrl_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the chip-control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module chip_ctrl_tb -o chip_ctrl_sim

out=$(./obj_dir/chip_ctrl_sim)
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
  exit 0
else
  exit 1
fi

// File: tests/chip_ctrl_tb.sv
/*
 * Chip-control testbench with clock and reset, a stimulus table holding a
 * reference model of CLK_CTRL and PAD_CFG, the APB access task, checks and timeout
 */

module chip_ctrl_tb;

  import chip_ctrl_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int MAX_ENTRIES = 32;
  localparam int OP_WR       = 0;
  localparam int OP_RD       = 1;
  localparam int OP_CHK      = 2;
  // Register reference values
  localparam logic [31:0] EXP_CLK_RESET = 32'h0000_0007;
  localparam logic [31:0] EXP_CLK_MASK  = 32'h0000_0077;

  logic        soc_clk, rst_n;
  logic        psel, penable, pwrite, pready, pslverr;
  logic [11:0] paddr;
  logic [31:0] pwdata, prdata;
  logic        pad_byp, jtag_byp;
  logic        soc_en, per_en, slow_en, soc_byp, per_byp, slow_byp;
  logic [7:0]  gpio_out, gpio_tx_en, gpio_in, pad_in, pad_out, pad_oe;
  logic [3:0]  timer_ch;

  integer seed = 32'h36ce_a33d;
  int     n_entries = 0;
  int     err_cnt = 0;
  int     check_cnt = 0;
  int     cycle_cnt = 0;
  int     timeout_limit = 0;
  // Reference register contents while the table is built
  logic [31:0] model_clk = EXP_CLK_RESET;
  logic [7:0]  model_pad = '0;

  // Stimulus and expected values in one array per column
  int          op_tab [MAX_ENTRIES];
  logic [11:0] addr_tab [MAX_ENTRIES];
  logic [31:0] wdata_tab [MAX_ENTRIES];
  logic [31:0] rdata_exp_tab [MAX_ENTRIES];
  logic        err_exp_tab [MAX_ENTRIES];
  logic [1:0]  byp_tab [MAX_ENTRIES];
  logic [7:0]  gpio_out_tab [MAX_ENTRIES];
  logic [7:0]  gpio_tx_en_tab [MAX_ENTRIES];
  logic [7:0]  pad_in_tab [MAX_ENTRIES];
  logic [3:0]  timer_tab [MAX_ENTRIES];
  // {slow_byp, per_byp, soc_byp, slow_en, per_en, soc_en}
  logic [5:0]  clk_exp_tab [MAX_ENTRIES];
  logic [7:0]  pad_out_exp_tab [MAX_ENTRIES];
  logic [7:0]  pad_oe_exp_tab [MAX_ENTRIES];

  chip_ctrl_top i_chip_ctrl_top (
    .soc_clk_i         ( soc_clk    ),
    .rst_n_i           ( rst_n      ),
    .psel_i            ( psel       ),
    .penable_i         ( penable    ),
    .pwrite_i          ( pwrite     ),
    .paddr_i           ( paddr      ),
    .pwdata_i          ( pwdata     ),
    .prdata_o          ( prdata     ),
    .pready_o          ( pready     ),
    .pslverr_o         ( pslverr    ),
    .pad_clk_byp_en_i  ( pad_byp    ),
    .jtag_clk_byp_en_i ( jtag_byp   ),
    .soc_clk_en_o      ( soc_en     ),
    .per_clk_en_o      ( per_en     ),
    .slow_clk_en_o     ( slow_en    ),
    .soc_clk_byp_en_o  ( soc_byp    ),
    .per_clk_byp_en_o  ( per_byp    ),
    .slow_clk_byp_en_o ( slow_byp   ),
    .gpio_out_i        ( gpio_out   ),
    .gpio_tx_en_i      ( gpio_tx_en ),
    .gpio_in_o         ( gpio_in    ),
    .timer_ch_i        ( timer_ch   ),
    .pad_in_i          ( pad_in     ),
    .pad_out_o         ( pad_out    ),
    .pad_oe_o          ( pad_oe     )
  );

  initial begin
    soc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) soc_clk = ~soc_clk;
  end

  // Run limit is known once the table is built
  always @(posedge soc_clk) begin
    cycle_cnt++;
    if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
      $display("Timeout: run did not complete within %0d cycles", timeout_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Table construction
  //////////////////////////////////////////////////////////////////////////
  task automatic add_entry(int op, logic [11:0] addr, logic [31:0] wdata, logic [1:0] byp);
    logic [31:0] rnd;
    logic        in_map;
    logic        any_byp;
    int          k;
    rnd = $random(seed);
    in_map = (addr <= 12'h0FF) || ((addr >= 12'h400) && (addr <= 12'h4FF));
    // Only offset 0 of each region holds a register
    if (op == OP_WR && addr == 12'h000) model_clk = wdata & EXP_CLK_MASK;
    if (op == OP_WR && addr == 12'h400) model_pad = wdata[7:0];
    op_tab[n_entries]         = op;
    addr_tab[n_entries]       = addr;
    wdata_tab[n_entries]      = wdata;
    byp_tab[n_entries]        = byp;
    gpio_out_tab[n_entries]   = rnd[7:0];
    gpio_tx_en_tab[n_entries] = rnd[15:8];
    pad_in_tab[n_entries]     = rnd[23:16];
    timer_tab[n_entries]      = rnd[27:24];
    err_exp_tab[n_entries]    = !in_map;
    if (addr == 12'h000) rdata_exp_tab[n_entries] = model_clk;
    else if (addr == 12'h400) rdata_exp_tab[n_entries] = {24'h0, model_pad};
    else rdata_exp_tab[n_entries] = '0;
    // Either global source forces all three bypasses
    any_byp = byp[0] || byp[1];
    clk_exp_tab[n_entries] = {model_clk[6] || any_byp, model_clk[5] || any_byp,
                              model_clk[4] || any_byp, model_clk[2:0]};
    for (k = 0; k < N_PADS; k++) begin
      if (model_pad[k]) begin
        pad_out_exp_tab[n_entries][k] = rnd[24 + (k % N_TIMER_CH)];
        pad_oe_exp_tab[n_entries][k]  = 1'b1;
      end else begin
        pad_out_exp_tab[n_entries][k] = rnd[k];
        pad_oe_exp_tab[n_entries][k]  = rnd[8 + k];
      end
    end
    n_entries++;
  endtask

  task automatic build_table;
    logic [31:0] wd;
    // Reset state of both registers
    add_entry(OP_RD, 12'h000, '0, 2'b00);
    add_entry(OP_RD, 12'h400, '0, 2'b00);
    // Random CLK_CTRL write and readback
    wd = $random(seed);
    add_entry(OP_WR, 12'h000, wd, 2'b00);
    add_entry(OP_RD, 12'h000, '0, 2'b00);
    // Clear the bypass bits and walk the global sources
    wd = $random(seed);
    add_entry(OP_WR, 12'h000, wd & ~32'h0000_0070, 2'b00);
    add_entry(OP_CHK, 12'h000, '0, 2'b01);
    add_entry(OP_CHK, 12'h000, '0, 2'b10);
    add_entry(OP_CHK, 12'h000, '0, 2'b11);
    add_entry(OP_CHK, 12'h000, '0, 2'b00);
    // Pad functions and mux rule
    wd = $random(seed);
    add_entry(OP_WR, 12'h400, wd, 2'b00);
    add_entry(OP_CHK, 12'h000, '0, 2'b00);
    add_entry(OP_CHK, 12'h000, '0, 2'b00);
    add_entry(OP_RD, 12'h400, '0, 2'b00);
    add_entry(OP_RD, 12'h404, '0, 2'b00);
    // Unmapped address leaves both registers unchanged
    wd = $random(seed);
    add_entry(OP_WR, 12'h800, wd, 2'b00);
    add_entry(OP_RD, 12'h800, '0, 2'b00);
    add_entry(OP_RD, 12'h000, '0, 2'b00);
    add_entry(OP_RD, 12'h400, '0, 2'b00);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Drive and check helpers
  //////////////////////////////////////////////////////////////////////////
  // Inputs change just after the rising edge
  task automatic next_cycle;
    @(posedge soc_clk);
    #1;
  endtask

  task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
    check_cnt++;
    if (exp !== act) begin
      $display("FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  // Setup and access cycle with the response sampled mid-cycle
  task automatic apb_access(int i);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = (op_tab[i] == OP_WR);
    paddr   = addr_tab[i];
    pwdata  = wdata_tab[i];
    #2;
    check_val("pready_o", 32'h0, 32'(pready));
    check_val("pslverr_o", 32'h0, 32'(pslverr));
    next_cycle();
    penable = 1'b1;
    #2;
    check_val("pready_o", 32'h1, 32'(pready));
    check_val("pslverr_o", 32'(err_exp_tab[i]), 32'(pslverr));
    // Unmapped writes return zero data as well
    if (op_tab[i] == OP_RD || err_exp_tab[i]) begin
      check_val("prdata_o", rdata_exp_tab[i], prdata);
    end
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic check_outputs(int i);
    check_val("soc_clk_en_o", 32'(clk_exp_tab[i][0]), 32'(soc_en));
    check_val("per_clk_en_o", 32'(clk_exp_tab[i][1]), 32'(per_en));
    check_val("slow_clk_en_o", 32'(clk_exp_tab[i][2]), 32'(slow_en));
    check_val("soc_clk_byp_en_o", 32'(clk_exp_tab[i][3]), 32'(soc_byp));
    check_val("per_clk_byp_en_o", 32'(clk_exp_tab[i][4]), 32'(per_byp));
    check_val("slow_clk_byp_en_o", 32'(clk_exp_tab[i][5]), 32'(slow_byp));
    check_val("pad_out_o", 32'(pad_out_exp_tab[i]), 32'(pad_out));
    check_val("pad_oe_o", 32'(pad_oe_exp_tab[i]), 32'(pad_oe));
    check_val("gpio_in_o", 32'(pad_in_tab[i]), 32'(gpio_in));
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////////
  initial begin
    rst_n      = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    pad_byp    = 1'b0;
    jtag_byp   = 1'b0;
    gpio_out   = '0;
    gpio_tx_en = '0;
    timer_ch   = '0;
    pad_in     = '0;
    build_table();
    timeout_limit = 16 + 6 * n_entries;
    repeat (8) @(posedge soc_clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < n_entries; i++) begin
      next_cycle();
      pad_byp    = byp_tab[i][0];
      jtag_byp   = byp_tab[i][1];
      gpio_out   = gpio_out_tab[i];
      gpio_tx_en = gpio_tx_en_tab[i];
      timer_ch   = timer_tab[i];
      pad_in     = pad_in_tab[i];
      if (op_tab[i] != OP_CHK) apb_access(i);
      #2;
      check_outputs(i);
    end
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: hw/chip_ctrl_top.sv
/*
 * Chip-control top level: APB region decoder, clock control registers,
 * pad configuration register and pad multiplexer
 */

module chip_ctrl_top (
  input  logic                                 soc_clk_i,
  input  logic                                 rst_n_i,
  // APB slave port from the SoC
  input  logic                                 psel_i,
  input  logic                                 penable_i,
  input  logic                                 pwrite_i,
  input  logic [chip_ctrl_pkg::APB_ADDR_W-1:0]  paddr_i,
  input  logic [chip_ctrl_pkg::APB_DATA_W-1:0]  pwdata_i,
  output logic [chip_ctrl_pkg::APB_DATA_W-1:0]  prdata_o,
  output logic                                 pready_o,
  output logic                                 pslverr_o,
  // Global bypass from the dedicated pad and the JTAG TAP
  input  logic                                 pad_clk_byp_en_i,
  input  logic                                 jtag_clk_byp_en_i,
  // Clock generator controls
  output logic                                 soc_clk_en_o,
  output logic                                 per_clk_en_o,
  output logic                                 slow_clk_en_o,
  output logic                                 soc_clk_byp_en_o,
  output logic                                 per_clk_byp_en_o,
  output logic                                 slow_clk_byp_en_o,
  // Pad bank
  input  logic [chip_ctrl_pkg::N_PADS-1:0]      gpio_out_i,
  input  logic [chip_ctrl_pkg::N_PADS-1:0]      gpio_tx_en_i,
  output logic [chip_ctrl_pkg::N_PADS-1:0]      gpio_in_o,
  input  logic [chip_ctrl_pkg::N_TIMER_CH-1:0]  timer_ch_i,
  input  logic [chip_ctrl_pkg::N_PADS-1:0]      pad_in_i,
  output logic [chip_ctrl_pkg::N_PADS-1:0]      pad_out_o,
  output logic [chip_ctrl_pkg::N_PADS-1:0]      pad_oe_o
);

  import chip_ctrl_pkg::*;

  logic                  clk_sel;
  logic                  pad_sel;
  logic [APB_DATA_W-1:0] clk_rdata;
  logic [APB_DATA_W-1:0] pad_rdata;
  logic [N_PADS-1:0]     pad_func;

  ////////////////////////////////////////////////////////////////////////////
  // APB region decode
  ////////////////////////////////////////////////////////////////////////////
  apb_region_demux i_apb_region_demux (
    .soc_clk_i   ( soc_clk_i ),
    .rst_n_i     ( rst_n_i   ),
    .psel_i      ( psel_i    ),
    .penable_i   ( penable_i ),
    .paddr_i     ( paddr_i   ),
    .clk_rdata_i ( clk_rdata ),
    .pad_rdata_i ( pad_rdata ),
    .clk_sel_o   ( clk_sel   ),
    .pad_sel_o   ( pad_sel   ),
    .prdata_o    ( prdata_o  ),
    .pready_o    ( pready_o  ),
    .pslverr_o   ( pslverr_o )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Clock control
  ////////////////////////////////////////////////////////////////////////////
  clk_ctrl_regs i_clk_ctrl_regs (
    .soc_clk_i         ( soc_clk_i         ),
    .rst_n_i           ( rst_n_i           ),
    .sel_i             ( clk_sel           ),
    .penable_i         ( penable_i         ),
    .pwrite_i          ( pwrite_i          ),
    .paddr_i           ( paddr_i           ),
    .pwdata_i          ( pwdata_i          ),
    .pad_clk_byp_en_i  ( pad_clk_byp_en_i  ),
    .jtag_clk_byp_en_i ( jtag_clk_byp_en_i ),
    .rdata_o           ( clk_rdata         ),
    .soc_clk_en_o      ( soc_clk_en_o      ),
    .per_clk_en_o      ( per_clk_en_o      ),
    .slow_clk_en_o     ( slow_clk_en_o     ),
    .soc_clk_byp_en_o  ( soc_clk_byp_en_o  ),
    .per_clk_byp_en_o  ( per_clk_byp_en_o  ),
    .slow_clk_byp_en_o ( slow_clk_byp_en_o )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Pad configuration and muxing
  ////////////////////////////////////////////////////////////////////////////
  pad_cfg_regs i_pad_cfg_regs (
    .soc_clk_i  ( soc_clk_i ),
    .rst_n_i    ( rst_n_i   ),
    .sel_i      ( pad_sel   ),
    .penable_i  ( penable_i ),
    .pwrite_i   ( pwrite_i  ),
    .paddr_i    ( paddr_i   ),
    .pwdata_i   ( pwdata_i  ),
    .rdata_o    ( pad_rdata ),
    .pad_func_o ( pad_func  )
  );

  pad_mux i_pad_mux (
    .pad_func_i   ( pad_func     ),
    .gpio_out_i   ( gpio_out_i   ),
    .gpio_tx_en_i ( gpio_tx_en_i ),
    .gpio_in_o    ( gpio_in_o    ),
    .timer_ch_i   ( timer_ch_i   ),
    .pad_in_i     ( pad_in_i     ),
    .pad_out_o    ( pad_out_o    ),
    .pad_oe_o     ( pad_oe_o     )
  );

endmodule

// File: hw/pad_mux.sv
/*
 * Pad multiplexer: per pad output and output enable from GPIO or a timer
 * channel, and pad input return to the GPIO block
 */

module pad_mux (
  input  logic [chip_ctrl_pkg::N_PADS-1:0]     pad_func_i,
  // GPIO side
  input  logic [chip_ctrl_pkg::N_PADS-1:0]     gpio_out_i,
  input  logic [chip_ctrl_pkg::N_PADS-1:0]     gpio_tx_en_i,
  output logic [chip_ctrl_pkg::N_PADS-1:0]     gpio_in_o,
  // Timer PWM channels
  input  logic [chip_ctrl_pkg::N_TIMER_CH-1:0] timer_ch_i,
  // Pad side
  input  logic [chip_ctrl_pkg::N_PADS-1:0]     pad_in_i,
  output logic [chip_ctrl_pkg::N_PADS-1:0]     pad_out_o,
  output logic [chip_ctrl_pkg::N_PADS-1:0]     pad_oe_o
);

  import chip_ctrl_pkg::*;

  // Timer channels repeat across the bank
  always_comb begin
    for (int k = 0; k < N_PADS; k++) begin
      if (pad_func_i[k]) begin
        // Timer output is always driven
        pad_out_o[k] = timer_ch_i[k % N_TIMER_CH];
        pad_oe_o[k]  = 1'b1;
      end else begin
        pad_out_o[k] = gpio_out_i[k];
        pad_oe_o[k]  = gpio_tx_en_i[k];
      end
    end
  end

  // GPIO sees the pad level whatever the function
  assign gpio_in_o = pad_in_i;

endmodule

// File: hw/pad_cfg_regs.sv
/*
 * Pad configuration register block: PAD_CFG holds one function bit per
 * pad, 0 for GPIO and 1 for timer
 */

module pad_cfg_regs (
  input  logic                                soc_clk_i,
  input  logic                                rst_n_i,
  // APB from the region decoder
  input  logic                                sel_i,
  input  logic                                penable_i,
  input  logic                                pwrite_i,
  input  logic [chip_ctrl_pkg::APB_ADDR_W-1:0] paddr_i,
  input  logic [chip_ctrl_pkg::APB_DATA_W-1:0] pwdata_i,
  output logic [chip_ctrl_pkg::APB_DATA_W-1:0] rdata_o,
  // Function select per pad
  output logic [chip_ctrl_pkg::N_PADS-1:0]     pad_func_o
);

  import chip_ctrl_pkg::*;

  logic [N_PADS-1:0] pad_func_q;
  logic              offset_hit;
  logic              wr_en;

  assign offset_hit = (paddr_i[REGION_OFFSET_W-1:0] == '0);
  assign wr_en      = sel_i && penable_i && pwrite_i && offset_hit;

  // All pads come up as GPIO
  always_ff @(posedge soc_clk_i) begin
    if (!rst_n_i) begin
      pad_func_q <= '0;
    end else if (wr_en) begin
      // Upper write bits are dropped
      pad_func_q <= pwdata_i[N_PADS-1:0];
    end
  end

  // Zero-extended readback, other offsets read zero
  always_comb begin
    rdata_o = '0;
    if (offset_hit) begin
      rdata_o[N_PADS-1:0] = pad_func_q;
    end
  end

  assign pad_func_o = pad_func_q;

endmodule

// File: hw/clk_ctrl_regs.sv
/*
 * Clock control register block: CLK_CTRL with enable and bypass bits,
 * combined with the pad and JTAG global bypass sources
 */

module clk_ctrl_regs (
  input  logic                                soc_clk_i,
  input  logic                                rst_n_i,
  // APB from the region decoder
  input  logic                                sel_i,
  input  logic                                penable_i,
  input  logic                                pwrite_i,
  input  logic [chip_ctrl_pkg::APB_ADDR_W-1:0] paddr_i,
  input  logic [chip_ctrl_pkg::APB_DATA_W-1:0] pwdata_i,
  // Global bypass sources
  input  logic                                pad_clk_byp_en_i,
  input  logic                                jtag_clk_byp_en_i,
  output logic [chip_ctrl_pkg::APB_DATA_W-1:0] rdata_o,
  // Clock generator controls
  output logic                                soc_clk_en_o,
  output logic                                per_clk_en_o,
  output logic                                slow_clk_en_o,
  output logic                                soc_clk_byp_en_o,
  output logic                                per_clk_byp_en_o,
  output logic                                slow_clk_byp_en_o
);

  import chip_ctrl_pkg::*;

  logic [APB_DATA_W-1:0] clk_ctrl_q;
  logic                  offset_hit;
  logic                  wr_en;
  logic                  global_byp;

  // Single register at offset 0
  assign offset_hit = (paddr_i[REGION_OFFSET_W-1:0] == '0);
  assign wr_en      = sel_i && penable_i && pwrite_i && offset_hit;

  // Write lands on the edge that ends the access cycle
  always_ff @(posedge soc_clk_i) begin
    if (!rst_n_i) begin
      clk_ctrl_q <= CLK_CTRL_RESET;
    end else if (wr_en) begin
      clk_ctrl_q <= pwdata_i & CLK_CTRL_MASK;
    end
  end

  // Other offsets read zero
  assign rdata_o = offset_hit ? clk_ctrl_q : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Clock generator controls
  ////////////////////////////////////////////////////////////////////////////
  assign soc_clk_en_o  = clk_ctrl_q[SOC_EN_BIT];
  assign per_clk_en_o  = clk_ctrl_q[PER_EN_BIT];
  assign slow_clk_en_o = clk_ctrl_q[SLOW_EN_BIT];

  // Pad or JTAG forces every domain into bypass
  assign global_byp = pad_clk_byp_en_i || jtag_clk_byp_en_i;

  assign soc_clk_byp_en_o  = clk_ctrl_q[SOC_BYP_BIT] || global_byp;
  assign per_clk_byp_en_o  = clk_ctrl_q[PER_BYP_BIT] || global_byp;
  assign slow_clk_byp_en_o = clk_ctrl_q[SLOW_BYP_BIT] || global_byp;

  // Unused bits stay clear across reset and writes
  a_clk_ctrl_masked: assert property (
    @(posedge soc_clk_i) disable iff (!rst_n_i)
    (clk_ctrl_q & ~CLK_CTRL_MASK) == '0
  );

endmodule

// File: hw/apb_region_demux.sv
/*
 * APB region decoder: address rules to select index, per-region select
 * levels, read-data return mux and the default error responder
 */

module apb_region_demux (
  input  logic                                soc_clk_i,
  input  logic                                rst_n_i,
  // APB request from the SoC
  input  logic                                psel_i,
  input  logic                                penable_i,
  input  logic [chip_ctrl_pkg::APB_ADDR_W-1:0] paddr_i,
  // Read data from the regions
  input  logic [chip_ctrl_pkg::APB_DATA_W-1:0] clk_rdata_i,
  input  logic [chip_ctrl_pkg::APB_DATA_W-1:0] pad_rdata_i,
  // Region selects
  output logic                                clk_sel_o,
  output logic                                pad_sel_o,
  // APB response
  output logic [chip_ctrl_pkg::APB_DATA_W-1:0] prdata_o,
  output logic                                pready_o,
  output logic                                pslverr_o
);

  import chip_ctrl_pkg::*;

  logic [REGION_SEL_W-1:0] region_idx;
  logic                    access_phase;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////
  // Default index goes to the error responder
  always_comb begin
    region_idx = REGION_IDX_ERR;
    if ((paddr_i >= CLK_CTRL_START) && (paddr_i <= CLK_CTRL_END)) begin
      region_idx = REGION_IDX_CLK;
    end else if ((paddr_i >= PAD_CFG_START) && (paddr_i <= PAD_CFG_END)) begin
      region_idx = REGION_IDX_PAD;
    end
  end

  // Selects follow psel through setup and access
  assign clk_sel_o = psel_i && (region_idx == REGION_IDX_CLK);
  assign pad_sel_o = psel_i && (region_idx == REGION_IDX_PAD);

  ////////////////////////////////////////////////////////////////////////////
  // Response path
  ////////////////////////////////////////////////////////////////////////////
  assign access_phase = psel_i && penable_i;

  // No wait states in any region
  assign pready_o = access_phase;

  // Error responder returns zero data
  always_comb begin
    case (region_idx)
      REGION_IDX_CLK: prdata_o = clk_rdata_i;
      REGION_IDX_PAD: prdata_o = pad_rdata_i;
      default:        prdata_o = '0;
    endcase
  end

  // Error only in the access cycle of an unmapped address
  assign pslverr_o = access_phase && (region_idx == REGION_IDX_ERR);

  ////////////////////////////////////////////////////////////////////////////
  // Protocol checks
  ////////////////////////////////////////////////////////////////////////////
  a_slverr_in_access: assert property (
    @(posedge soc_clk_i) disable iff (!rst_n_i)
    pslverr_o |-> penable_i
  );

  // Regions never overlap
  a_sel_onehot: assert property (
    @(posedge soc_clk_i) disable iff (!rst_n_i)
    $onehot0({clk_sel_o, pad_sel_o})
  );

endmodule

// File: hw/chip_ctrl_pkg.sv
/*
 * Chip-control package: APB widths, region address map, region select
 * indices, pad bank sizes and CLK_CTRL bit layout with reset and mask values
 */

package chip_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // APB port
  ////////////////////////////////////////////////////////////////////////////
  localparam int unsigned APB_ADDR_W = 12;
  localparam int unsigned APB_DATA_W = 32;

  ////////////////////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////////////////////
  // Clock control region, inclusive bounds
  localparam logic [APB_ADDR_W-1:0] CLK_CTRL_START = 12'h000;
  localparam logic [APB_ADDR_W-1:0] CLK_CTRL_END   = 12'h0FF;
  // Pad configuration region, inclusive bounds
  localparam logic [APB_ADDR_W-1:0] PAD_CFG_START  = 12'h400;
  localparam logic [APB_ADDR_W-1:0] PAD_CFG_END    = 12'h4FF;
  // Both regions are 256 bytes and aligned, so the offset is the low byte
  localparam int unsigned REGION_OFFSET_W = 8;

  // Decoded regions, plus index 0 for the error responder
  localparam int unsigned N_REGIONS    = 2;
  localparam int unsigned REGION_SEL_W = $clog2(N_REGIONS + 1);
  localparam logic [REGION_SEL_W-1:0] REGION_IDX_ERR = 2'd0;
  localparam logic [REGION_SEL_W-1:0] REGION_IDX_CLK = 2'd1;
  localparam logic [REGION_SEL_W-1:0] REGION_IDX_PAD = 2'd2;

  ////////////////////////////////////////////////////////////////////////////
  // Pad bank
  ////////////////////////////////////////////////////////////////////////////
  localparam int unsigned N_PADS     = 8;
  localparam int unsigned N_TIMER_CH = 4;

  // CLK_CTRL layout: enables in the low nibble, bypasses above
  localparam int unsigned SOC_EN_BIT   = 0;
  localparam int unsigned PER_EN_BIT   = 1;
  localparam int unsigned SLOW_EN_BIT  = 2;
  localparam int unsigned SOC_BYP_BIT  = 4;
  localparam int unsigned PER_BYP_BIT  = 5;
  localparam int unsigned SLOW_BYP_BIT = 6;

  // All clocks enabled, no bypass
  localparam logic [APB_DATA_W-1:0] CLK_CTRL_RESET = 32'h0000_0007;
  localparam logic [APB_DATA_W-1:0] CLK_CTRL_MASK  = 32'h0000_0077;

endpackage
